//--- include/sdhc_macros.svh
`ifndef SDHC_MACROS_SVH
`define SDHC_MACROS_SVH

// bus word and register index widths
`define SDHC_DATA_W 32
`define SDHC_IDX_W 6

// register word indices, byte address bits 7:2
`define SDHC_REG_ARG2 6'h00
`define SDHC_REG_BLK 6'h01
`define SDHC_REG_ARG1 6'h02
`define SDHC_REG_CMD 6'h03
`define SDHC_REG_RESP0 6'h04
`define SDHC_REG_RESP1 6'h05
`define SDHC_REG_RESP2 6'h06
`define SDHC_REG_RESP3 6'h07
`define SDHC_REG_PSTATE 6'h09
`define SDHC_REG_HOSTCTL 6'h0A
`define SDHC_REG_CLKCTL 6'h0B
`define SDHC_REG_INTSTAT 6'h0C
`define SDHC_REG_INTEN 6'h0D
`define SDHC_REG_SIGEN 6'h0E
`define SDHC_REG_ACMDERR 6'h0F
`define SDHC_REG_CAPS 6'h10
`define SDHC_REG_ADMA 6'h16
`define SDHC_REG_VERSION 6'h3F

// read-only constant words
`define SDHC_CAPS_VAL 32'h012C32B2
`define SDHC_VERSION_VAL 32'h00020000

// auto cmd23: index 23, crc and index checks, short response
`define SDHC_ACMD23_CMD 14'h171a
`define SDHC_ACMD23_RESP_OK 16'h0900

// upper half-word write to the command register issues the command
`define SDHC_CMD_STRB 4'hC

// bit positions in the command core status
`define SDHC_INT_CMD_CC 0
`define SDHC_INT_CMD_EI 1
`define SDHC_INT_CMD_CTE 2
`define SDHC_INT_CMD_CCRCE 3
`define SDHC_INT_CMD_CIE 4
`define SDHC_INT_CMD_DC 5

// status and interrupt widths
`define SDHC_CMD_ST_W 6
`define SDHC_DAT_ST_W 5
`define SDHC_INT_W 29
`define SDHC_TOUT_W 32

`endif

//--- verilog/sdhc_pkg.sv
`include "sdhc_macros.svh"

package sdhc_pkg;

	// one accepted axi write beat, already turned into a word index
	typedef struct packed {
		logic valid;
		logic [`SDHC_IDX_W-1:0] index;
		logic [`SDHC_DATA_W-1:0] data;
		logic [`SDHC_DATA_W/8-1:0] strb;
	} reg_wr_t;

	// controls towards the sd command and data cores
	typedef struct packed {
		logic [7:0] clock_divisor;
		logic [13:0] command;
		logic [31:0] argument;
		logic [1:0] software_reset;
		logic [11:0] block_size;
		logic [15:0] block_count;
		logic [`SDHC_TOUT_W-1:0] timeout;
		logic bus_width_4;
		logic bus_width_8;
		logic data_dir;
		logic [1:0] dma_blk_en;
		logic blk_gap_req;
		logic [31:0] adma_addr;
	} sd_ctrl_t;

	// status back from the sd cores
	typedef struct packed {
		logic clk_stable;
		logic [31:0] resp0;
		logic [31:0] resp1;
		logic [31:0] resp2;
		logic [31:0] resp3;
		logic [`SDHC_CMD_ST_W-1:0] cmd_int_st;
		logic [`SDHC_DAT_ST_W-1:0] dat_int_st;
		logic [1:0] dma_int;
		logic write_active;
		logic read_active;
		logic dat_line_act;
		logic cmd_inh_dat;
		logic com_inh_cmd;
		logic cc_pulse;
	} sd_stat_t;

	// interrupt words for the interrupt controller
	typedef struct packed {
		logic [`SDHC_INT_W-1:0] status;
		logic [`SDHC_INT_W-1:0] enable;
		logic [`SDHC_INT_W-1:0] sig_en;
	} int_out_t;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		WAIT_CC = 2'b01,
		SEND = 2'b10
	} acmd_state_e;

endpackage

//--- verilog/sdhc_axil_slave.sv
module sdhc_axil_slave (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [31:0] s_axi_awaddr_i,
	input logic s_axi_awvalid_i,
	output logic s_axi_awready_o,
	input logic [31:0] s_axi_wdata_i,
	input logic [3:0] s_axi_wstrb_i,
	input logic s_axi_wvalid_i,
	output logic s_axi_wready_o,
	output logic [1:0] s_axi_bresp_o,
	output logic s_axi_bvalid_o,
	input logic s_axi_bready_i,
	input logic [31:0] s_axi_araddr_i,
	input logic s_axi_arvalid_i,
	output logic s_axi_arready_o,
	output logic [31:0] s_axi_rdata_o,
	output logic [1:0] s_axi_rresp_o,
	output logic s_axi_rvalid_o,
	input logic s_axi_rready_i,
	input logic [31:0] rdata_i,
	output sdhc_pkg::reg_wr_t wr_o,
	output logic [5:0] rd_idx_o
);

	logic aw_rdy_q;
	logic b_valid_q;
	logic [5:0] aw_idx_q;
	logic wr_fire;
	logic ar_rdy_q;
	logic r_valid_q;
	logic [5:0] ar_idx_q;
	logic [31:0] rdata_q;
	logic ar_fire;

	// address and data are taken together, one cycle of ready
	assign wr_fire = aw_rdy_q && s_axi_awvalid_i && s_axi_wvalid_i;
	assign ar_fire = ar_rdy_q && s_axi_arvalid_i;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			aw_rdy_q <= 1'b0;
			b_valid_q <= 1'b0;
		end
		else
		begin
			// no new write while the last response is still pending
			aw_rdy_q <= !aw_rdy_q && s_axi_awvalid_i && s_axi_wvalid_i && !b_valid_q;
			if (wr_fire)
				b_valid_q <= 1'b1;
			else if (s_axi_bready_i)
				b_valid_q <= 1'b0;
		end
	end

	// word index of the write, latched as ready goes up
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!aw_rdy_q && s_axi_awvalid_i && s_axi_wvalid_i)
			aw_idx_q <= s_axi_awaddr_i[7:2];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ar_rdy_q <= 1'b0;
			r_valid_q <= 1'b0;
		end
		else
		begin
			ar_rdy_q <= !ar_rdy_q && s_axi_arvalid_i && !r_valid_q;
			if (ar_fire)
				r_valid_q <= 1'b1;
			else if (s_axi_rready_i)
				r_valid_q <= 1'b0;
		end
	end

	// read index latched with arready, data sampled in the handshake cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!ar_rdy_q && s_axi_arvalid_i)
			ar_idx_q <= s_axi_araddr_i[7:2];
		if (ar_fire)
			rdata_q <= rdata_i;
	end

	always_comb
	begin
		wr_o.valid = wr_fire;
		wr_o.index = aw_idx_q;
		wr_o.data = s_axi_wdata_i;
		wr_o.strb = s_axi_wstrb_i;
	end

	assign rd_idx_o = ar_idx_q;
	assign s_axi_awready_o = aw_rdy_q;
	assign s_axi_wready_o = aw_rdy_q;
	assign s_axi_bvalid_o = b_valid_q;
	assign s_axi_arready_o = ar_rdy_q;
	assign s_axi_rvalid_o = r_valid_q;
	assign s_axi_rdata_o = rdata_q;
	// always OKAY
	assign s_axi_bresp_o = 2'b00;
	assign s_axi_rresp_o = 2'b00;

	// responses stay up until the master takes them
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);
	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

endmodule

//--- verilog/sdhc_regfile.sv
`include "sdhc_macros.svh"

module sdhc_regfile (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input sdhc_pkg::reg_wr_t wr_i,
	input logic [5:0] rd_idx_i,
	input sdhc_pkg::sd_stat_t stat_i,
	input logic [28:0] int_stat_i,
	input logic arg_sel_i,
	input logic cmd_sel_i,
	input logic seq_start_i,
	input logic [7:0] acmd_err_stat_i,
	output logic [31:0] rdata_o,
	output sdhc_pkg::sd_ctrl_t ctrl_o,
	output logic cmd_start_o,
	output logic int_wr_o,
	output logic [28:0] int_wr_data_o,
	output sdhc_pkg::int_out_t int_out_o,
	output logic [1:0] xfer_mode_o
);

	import sdhc_pkg::*;

	logic [31:0] arg2_q, blk_q, arg1_q, cmd_q;
	logic [31:0] pstate_q, hostctl_q, clkctl_q;
	logic [31:0] inten_q, sigen_q, adma_q;
	logic [31:0] wr_mask;
	logic cmd_wr;
	logic cmd_start_q;

	// byte lanes selected by the write strobes
	assign wr_mask = {{8{wr_i.strb[3]}}, {8{wr_i.strb[2]}}, {8{wr_i.strb[1]}}, {8{wr_i.strb[0]}}};
	// issue needs the command index half written on its own
	assign cmd_wr = wr_i.valid && wr_i.index == `SDHC_REG_CMD && wr_i.strb == `SDHC_CMD_STRB;

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val);
		return (old_val & ~wr_mask) | (wr_i.data & wr_mask);
	endfunction

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arg2_q <= '0;
			blk_q <= '0;
			arg1_q <= '0;
			cmd_q <= '0;
			pstate_q <= '0;
			hostctl_q <= '0;
			clkctl_q <= '0;
			inten_q <= '0;
			sigen_q <= '0;
			adma_q <= '0;
			cmd_start_q <= 1'b0;
		end
		else
		begin
			cmd_start_q <= cmd_wr;
			// software reset requests last one cycle
			clkctl_q[26:24] <= 3'b000;
			if (wr_i.valid)
			begin
				case (wr_i.index)
					`SDHC_REG_ARG2: arg2_q <= merge_bytes(arg2_q);
					`SDHC_REG_BLK: blk_q <= merge_bytes(blk_q);
					`SDHC_REG_ARG1: arg1_q <= merge_bytes(arg1_q);
					`SDHC_REG_CMD: cmd_q <= merge_bytes(cmd_q);
					`SDHC_REG_HOSTCTL: hostctl_q <= merge_bytes(hostctl_q);
					`SDHC_REG_CLKCTL: clkctl_q <= merge_bytes(clkctl_q);
					`SDHC_REG_INTEN: inten_q <= merge_bytes(inten_q);
					`SDHC_REG_SIGEN: sigen_q <= merge_bytes(sigen_q);
					`SDHC_REG_ADMA: adma_q <= merge_bytes(adma_q);
					default: ;
				endcase
			end
			// internal clock stable is status, not writable
			clkctl_q[1] <= stat_i.clk_stable;
			// present state follows the cores, cmd inhibit held until the core drops it
			pstate_q <= {7'b0, 1'b1, {4{~stat_i.dat_line_act}}, 4'hF, 6'b0,
				stat_i.read_active, stat_i.write_active, 5'b0, stat_i.dat_line_act,
				stat_i.cmd_inh_dat | stat_i.read_active,
				cmd_wr | seq_start_i | (pstate_q[0] & stat_i.com_inh_cmd)};
		end
	end

	// either a host write or the sequencer restarting the host command
	assign cmd_start_o = cmd_start_q | seq_start_i;

	// interrupt status write, masked to the strobed bytes
	assign int_wr_o = wr_i.valid && wr_i.index == `SDHC_REG_INTSTAT;
	assign int_wr_data_o = wr_i.data[28:0] & wr_mask[28:0];

	assign xfer_mode_o = cmd_q[3:2];

	always_comb
	begin
		ctrl_o.clock_divisor = clkctl_q[15:8] >> 1;
		// cmd23 word and argument 2 while the sequencer owns the bus
		ctrl_o.command = cmd_sel_i ? `SDHC_ACMD23_CMD : cmd_q[29:16];
		ctrl_o.argument = arg_sel_i ? arg2_q : arg1_q;
		// all, then cmd line, then dat line
		if (clkctl_q[24])
			ctrl_o.software_reset = 2'b11;
		else if (clkctl_q[25])
			ctrl_o.software_reset = 2'b01;
		else if (clkctl_q[26])
			ctrl_o.software_reset = 2'b10;
		else
			ctrl_o.software_reset = 2'b00;
		ctrl_o.block_size = blk_q[11:0];
		ctrl_o.block_count = blk_q[31:16];
		// timeout counts 2^(13+n) sd clocks
		ctrl_o.timeout = (`SDHC_TOUT_W'(1) << clkctl_q[19:16]) << 13;
		ctrl_o.bus_width_4 = hostctl_q[1];
		ctrl_o.bus_width_8 = hostctl_q[5];
		ctrl_o.data_dir = cmd_q[4];
		ctrl_o.dma_blk_en = cmd_q[1:0];
		ctrl_o.blk_gap_req = hostctl_q[16];
		ctrl_o.adma_addr = adma_q;
	end

	always_comb
	begin
		int_out_o.status = int_stat_i;
		int_out_o.enable = inten_q[28:0];
		int_out_o.sig_en = sigen_q[28:0];
	end

	// read decode, index already latched by the axi slave
	always_comb
	begin
		case (rd_idx_i)
			`SDHC_REG_ARG2: rdata_o = arg2_q;
			`SDHC_REG_BLK: rdata_o = blk_q;
			`SDHC_REG_ARG1: rdata_o = arg1_q;
			`SDHC_REG_CMD: rdata_o = cmd_q;
			`SDHC_REG_RESP0: rdata_o = stat_i.resp0;
			`SDHC_REG_RESP1: rdata_o = stat_i.resp1;
			`SDHC_REG_RESP2: rdata_o = stat_i.resp2;
			`SDHC_REG_RESP3: rdata_o = stat_i.resp3;
			`SDHC_REG_PSTATE: rdata_o = pstate_q;
			`SDHC_REG_HOSTCTL: rdata_o = hostctl_q;
			`SDHC_REG_CLKCTL: rdata_o = clkctl_q;
			// only enabled status bits are visible
			`SDHC_REG_INTSTAT: rdata_o = {3'b000, int_stat_i & inten_q[28:0]};
			`SDHC_REG_INTEN: rdata_o = inten_q;
			`SDHC_REG_SIGEN: rdata_o = sigen_q;
			`SDHC_REG_ACMDERR: rdata_o = {24'b0, acmd_err_stat_i};
			`SDHC_REG_CAPS: rdata_o = `SDHC_CAPS_VAL;
			`SDHC_REG_ADMA: rdata_o = adma_q;
			`SDHC_REG_VERSION: rdata_o = `SDHC_VERSION_VAL;
			default: rdata_o = '0;
		endcase
	end

endmodule

//--- verilog/sdhc_int_status.sv
`include "sdhc_macros.svh"

module sdhc_int_status (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input sdhc_pkg::sd_stat_t stat_i,
	input logic int_wr_i,
	input logic [28:0] int_wr_data_i,
	input logic cc_mask_i,
	input logic seq_int_rst_i,
	input logic acmd_err_i,
	output logic [28:0] int_stat_o,
	output logic cmd_int_rst_o,
	output logic dat_int_rst_o
);

	logic [28:0] mask_q;
	logic [28:0] int_stat_q;
	logic [28:0] int_src;
	logic wr_pulse_q;
	logic core_active;

	assign core_active = |stat_i.cmd_int_st || |stat_i.dat_int_st;

	// status sources placed at their sdhc bit positions
	assign int_src = {stat_i.dat_int_st[4], 2'b00, stat_i.dma_int[1], acmd_err_i, 1'b0,
		stat_i.dat_int_st[1], stat_i.dat_int_st[3:2],
		stat_i.cmd_int_st[`SDHC_INT_CMD_CIE], stat_i.cmd_int_st[`SDHC_INT_CMD_EI],
		stat_i.cmd_int_st[`SDHC_INT_CMD_CCRCE], stat_i.cmd_int_st[`SDHC_INT_CMD_CTE],
		14'b0, stat_i.dma_int[0] | stat_i.cmd_int_st[`SDHC_INT_CMD_DC],
		stat_i.cmd_int_st[`SDHC_INT_CMD_CC] & ~cc_mask_i};

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			mask_q <= '0;
			int_stat_q <= '0;
			wr_pulse_q <= 1'b0;
		end
		else
		begin
			wr_pulse_q <= int_wr_i;
			// written ones hide a bit until the cores go quiet
			if (int_wr_i)
				mask_q <= int_wr_data_i;
			else if (!core_active)
				mask_q <= '0;
			int_stat_q <= ~mask_q & int_src;
		end
	end

	assign int_stat_o = int_stat_q;
	// clear requests to the cores, sequencer can clear the cmd side too
	assign cmd_int_rst_o = wr_pulse_q | seq_int_rst_i;
	assign dat_int_rst_o = wr_pulse_q;

endmodule

//--- verilog/sdhc_acmd23_seq.sv
`include "sdhc_macros.svh"

module sdhc_acmd23_seq (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [1:0] xfer_mode_i,
	input logic cmd_start_i,
	input sdhc_pkg::sd_stat_t stat_i,
	input logic int_clr_i,
	output logic arg_sel_o,
	output logic cmd_sel_o,
	output logic cc_mask_o,
	output logic seq_start_o,
	output logic seq_int_rst_o,
	output logic acmd_err_o,
	output logic [7:0] acmd_err_stat_o
);

	import sdhc_pkg::*;

	acmd_state_e state_q;
	logic sel_q;
	logic cmd_err;
	logic resp_ok;

	assign cmd_err = stat_i.cmd_int_st[`SDHC_INT_CMD_EI] | stat_i.cmd_int_st[`SDHC_INT_CMD_CTE]
		| stat_i.cmd_int_st[`SDHC_INT_CMD_CCRCE] | stat_i.cmd_int_st[`SDHC_INT_CMD_CIE];
	// card status of the r1 response to cmd23
	assign resp_ok = stat_i.resp0[15:0] == `SDHC_ACMD23_RESP_OK;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state_q <= IDLE;
			sel_q <= 1'b0;
			seq_start_o <= 1'b0;
			seq_int_rst_o <= 1'b0;
			acmd_err_o <= 1'b0;
			acmd_err_stat_o <= '0;
		end
		else
		begin
			seq_start_o <= 1'b0;
			seq_int_rst_o <= 1'b0;
			case (state_q)
				IDLE:
				begin
					// auto cmd23 mode steers the next issue to cmd23
					sel_q <= xfer_mode_i == 2'b10;
					if (xfer_mode_i == 2'b10 && cmd_start_i)
						state_q <= WAIT_CC;
				end
				WAIT_CC:
				begin
					if (stat_i.cc_pulse)
					begin
						if (resp_ok)
						begin
							// hand the bus back and start the host command
							sel_q <= 1'b0;
							seq_start_o <= 1'b1;
							state_q <= SEND;
						end
						else
						begin
							acmd_err_o <= 1'b1;
							acmd_err_stat_o <= {3'b000, stat_i.cmd_int_st[`SDHC_INT_CMD_CIE],
								stat_i.cmd_int_st[`SDHC_INT_CMD_EI],
								stat_i.cmd_int_st[`SDHC_INT_CMD_CCRCE],
								stat_i.cmd_int_st[`SDHC_INT_CMD_CTE], 1'b0};
							state_q <= IDLE;
						end
					end
					else if (cmd_err)
						seq_int_rst_o <= 1'b1;
				end
				SEND:
				begin
					// wait for the host command to complete
					if (stat_i.cc_pulse)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
			// host clearing interrupt status also clears the error flag
			if (int_clr_i)
				acmd_err_o <= 1'b0;
		end
	end

	assign arg_sel_o = sel_q;
	assign cmd_sel_o = sel_q;
	assign cc_mask_o = sel_q;

	// no new command issue while the cmd23 response is outstanding
	a_no_issue_in_wait: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		state_q == WAIT_CC |-> !cmd_start_i);

endmodule

//--- verilog/sdhc_host_regs.sv
module sdhc_host_regs (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [31:0] s_axi_awaddr_i,
	input logic s_axi_awvalid_i,
	output logic s_axi_awready_o,
	input logic [31:0] s_axi_wdata_i,
	input logic [3:0] s_axi_wstrb_i,
	input logic s_axi_wvalid_i,
	output logic s_axi_wready_o,
	output logic [1:0] s_axi_bresp_o,
	output logic s_axi_bvalid_o,
	input logic s_axi_bready_i,
	input logic [31:0] s_axi_araddr_i,
	input logic s_axi_arvalid_i,
	output logic s_axi_arready_o,
	output logic [31:0] s_axi_rdata_o,
	output logic [1:0] s_axi_rresp_o,
	output logic s_axi_rvalid_o,
	input logic s_axi_rready_i,
	input sdhc_pkg::sd_stat_t sd_stat_i,
	output sdhc_pkg::sd_ctrl_t sd_ctrl_o,
	output logic cmd_start_o,
	output logic cmd_int_rst_o,
	output logic dat_int_rst_o,
	output sdhc_pkg::int_out_t int_out_o
);

	import sdhc_pkg::*;

	reg_wr_t wr;
	logic [5:0] rd_idx;
	logic [31:0] rdata;
	logic [28:0] int_stat;
	logic int_wr;
	logic [28:0] int_wr_data;
	logic [1:0] xfer_mode;
	logic arg_sel, cmd_sel, cc_mask;
	logic seq_start, seq_int_rst;
	logic acmd_err;
	logic [7:0] acmd_err_stat;

	sdhc_axil_slave u_axil (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_awaddr_i(s_axi_awaddr_i), .s_axi_awvalid_i(s_axi_awvalid_i),
		.s_axi_awready_o(s_axi_awready_o), .s_axi_wdata_i(s_axi_wdata_i),
		.s_axi_wstrb_i(s_axi_wstrb_i), .s_axi_wvalid_i(s_axi_wvalid_i),
		.s_axi_wready_o(s_axi_wready_o), .s_axi_bresp_o(s_axi_bresp_o),
		.s_axi_bvalid_o(s_axi_bvalid_o), .s_axi_bready_i(s_axi_bready_i),
		.s_axi_araddr_i(s_axi_araddr_i), .s_axi_arvalid_i(s_axi_arvalid_i),
		.s_axi_arready_o(s_axi_arready_o), .s_axi_rdata_o(s_axi_rdata_o),
		.s_axi_rresp_o(s_axi_rresp_o), .s_axi_rvalid_o(s_axi_rvalid_o),
		.s_axi_rready_i(s_axi_rready_i), .rdata_i(rdata), .wr_o(wr), .rd_idx_o(rd_idx)
	);

	sdhc_regfile u_regs (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_i(wr), .rd_idx_i(rd_idx), .stat_i(sd_stat_i), .int_stat_i(int_stat),
		.arg_sel_i(arg_sel), .cmd_sel_i(cmd_sel), .seq_start_i(seq_start),
		.acmd_err_stat_i(acmd_err_stat), .rdata_o(rdata), .ctrl_o(sd_ctrl_o),
		.cmd_start_o(cmd_start_o), .int_wr_o(int_wr), .int_wr_data_o(int_wr_data),
		.int_out_o(int_out_o), .xfer_mode_o(xfer_mode)
	);

	sdhc_int_status u_int (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.stat_i(sd_stat_i), .int_wr_i(int_wr), .int_wr_data_i(int_wr_data),
		.cc_mask_i(cc_mask), .seq_int_rst_i(seq_int_rst), .acmd_err_i(acmd_err),
		.int_stat_o(int_stat), .cmd_int_rst_o(cmd_int_rst_o), .dat_int_rst_o(dat_int_rst_o)
	);

	sdhc_acmd23_seq u_acmd23 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.xfer_mode_i(xfer_mode), .cmd_start_i(cmd_start_o), .stat_i(sd_stat_i),
		.int_clr_i(int_wr), .arg_sel_o(arg_sel), .cmd_sel_o(cmd_sel), .cc_mask_o(cc_mask),
		.seq_start_o(seq_start), .seq_int_rst_o(seq_int_rst), .acmd_err_o(acmd_err),
		.acmd_err_stat_o(acmd_err_stat)
	);

endmodule

//--- dv/tb_sdhc_host_regs.sv
`include "sdhc_macros.svh"

module tb_sdhc_host_regs;

	timeunit 1ns;
	timeprecision 1ps;

	import sdhc_pkg::*;

	// cycles a single wait may take before it gives up
	localparam int wait_limit = 64;

	logic clk;
	logic rst_n;
	logic [31:0] awaddr;
	logic [31:0] wdata;
	logic [31:0] araddr;
	logic [3:0] wstrb;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	logic [31:0] rdata;
	sd_stat_t stat;
	sd_ctrl_t ctrl;
	logic cmd_start, cmd_int_rst, dat_int_rst;
	int_out_t int_out;

	int errors;
	int timeouts;
	// filled in by the falling-edge monitor
	int start_cnt;
	logic [13:0] start_cmd;
	logic [31:0] start_arg;
	int cmd_rst_cnt;
	int dat_rst_cnt;
	int srst_cycles;
	logic [1:0] srst_code;

	sdhc_host_regs dut (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rst_n),
		.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
		.s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
		.s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
		.s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
		.s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
		.s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready), .sd_stat_i(stat),
		.sd_ctrl_o(ctrl), .cmd_start_o(cmd_start), .cmd_int_rst_o(cmd_int_rst),
		.dat_int_rst_o(dat_int_rst), .int_out_o(int_out)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// pulses counted mid-cycle where outputs are settled
	always @(negedge clk)
	begin
		if (cmd_start)
		begin
			start_cnt++;
			start_cmd = ctrl.command;
			start_arg = ctrl.argument;
		end
		if (cmd_int_rst)
			cmd_rst_cnt++;
		if (dat_int_rst)
			dat_rst_cnt++;
		if (ctrl.software_reset != 2'b00)
		begin
			srst_cycles++;
			srst_code = ctrl.software_reset;
		end
	end

	// inputs change 1 ns after the rising edge
	task automatic clock_to_drive();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [159:0] exp_val,
		input logic [159:0] act_val);
		assert (act_val === exp_val)
		else
		begin
			errors++;
			$display("ERROR %s: expected %0h actual %0h", name, exp_val, act_val);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout: no %s from the DUT within %0d cycles", what, wait_limit);
	endtask

	task automatic axi_write(input logic [5:0] idx, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		awaddr = {24'h0, idx, 2'b00};
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!awready && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!awready)
			report_timeout("awready");
		check_value("axi_write wready", 1'b1, wready);
		// handshake on the coming edge
		clock_to_drive();
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!bvalid && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!bvalid)
			report_timeout("bvalid");
		check_value("axi_write bresp", 2'b00, bresp);
		// response held one cycle before it is taken
		clock_to_drive();
		bready = 1'b1;
		clock_to_drive();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [5:0] idx, output logic [31:0] data);
		int n;
		araddr = {24'h0, idx, 2'b00};
		arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!arready)
			report_timeout("arready");
		clock_to_drive();
		arvalid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rvalid && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!rvalid)
			report_timeout("rvalid");
		data = rdata;
		check_value("axi_read rresp", 2'b00, rresp);
		clock_to_drive();
		rready = 1'b1;
		clock_to_drive();
		rready = 1'b0;
	endtask

	// expected word after a strobed write
	function automatic logic [31:0] strobe_merge(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		return res;
	endfunction

	// present state as the core status should fold into it
	function automatic logic [31:0] pstate_expect(input logic inhibit);
		logic [31:0] v;
		v = 32'h0;
		v[0] = inhibit;
		v[1] = stat.cmd_inh_dat | stat.read_active;
		v[2] = stat.dat_line_act;
		v[8] = stat.write_active;
		v[9] = stat.read_active;
		v[19:16] = 4'hF;
		v[23:20] = {4{~stat.dat_line_act}};
		v[24] = 1'b1;
		return v;
	endfunction

	// one-cycle command complete strobe from the command core
	task automatic pulse_cmd_complete();
		stat.cc_pulse = 1'b1;
		clock_to_drive();
		stat.cc_pulse = 1'b0;
	endtask

	task automatic reset_and_constants();
		sd_ctrl_t exp_ctrl;
		logic [31:0] rd;
		exp_ctrl = '0;
		// zero timeout field is still 2^13 clocks
		exp_ctrl.timeout = 32'h1 << 13;
		@(negedge clk);
		check_value("reset ctrl", exp_ctrl, ctrl);
		check_value("reset handshakes", 5'b00000, {awready, wready, bvalid, arready, rvalid});
		check_value("reset pulses", 3'b000, {cmd_start, cmd_int_rst, dat_int_rst});
		check_value("reset int_out", '0, int_out);
		clock_to_drive();
		axi_read(`SDHC_REG_VERSION, rd);
		check_value("reset version", `SDHC_VERSION_VAL, rd);
		axi_read(`SDHC_REG_CAPS, rd);
		check_value("reset caps", `SDHC_CAPS_VAL, rd);
	endtask

	task automatic byte_strobe_writes();
		logic [31:0] first, second, exp_val, rd;
		logic [7:0] div;
		logic [3:0] tsel;
		first = $urandom;
		second = $urandom;
		axi_write(`SDHC_REG_ARG2, first, 4'hF);
		axi_write(`SDHC_REG_ARG2, second, 4'b0101);
		axi_read(`SDHC_REG_ARG2, rd);
		check_value("byte_strobes arg2", strobe_merge(first, second, 4'b0101), rd);
		first = $urandom;
		second = $urandom;
		axi_write(`SDHC_REG_BLK, first, 4'hF);
		axi_write(`SDHC_REG_BLK, second, 4'b1010);
		exp_val = strobe_merge(first, second, 4'b1010);
		axi_read(`SDHC_REG_BLK, rd);
		check_value("byte_strobes blk", exp_val, rd);
		@(negedge clk);
		check_value("byte_strobes block_size", exp_val[11:0], ctrl.block_size);
		check_value("byte_strobes block_count", exp_val[31:16], ctrl.block_count);
		clock_to_drive();
		// divisor in 15:8 and timeout select in 19:16
		div = 8'($urandom);
		tsel = 4'($urandom);
		axi_write(`SDHC_REG_CLKCTL, {12'h0, tsel, div, 8'h00}, 4'hF);
		@(negedge clk);
		check_value("byte_strobes divisor", div >> 1, ctrl.clock_divisor);
		check_value("byte_strobes timeout", 32'h1 << (32'(tsel) + 13), ctrl.timeout);
		clock_to_drive();
		srst_cycles = 0;
		srst_code = 2'b00;
		// reset-all request in the top byte only
		axi_write(`SDHC_REG_CLKCTL, 32'h0100_0000, 4'h8);
		check_value("byte_strobes srst code", 2'b11, srst_code);
		check_value("byte_strobes srst cycles", 1, srst_cycles);
		axi_read(`SDHC_REG_CLKCTL, rd);
		check_value("byte_strobes clkctl", {12'h0, tsel, div, 8'h00}, rd);
	endtask

	task automatic command_issue();
		logic [31:0] arg1, cmd_word, rd;
		int starts;
		arg1 = $urandom;
		cmd_word = $urandom;
		axi_write(`SDHC_REG_ARG1, arg1, 4'hF);
		// command line busy until the core lets go
		stat.com_inh_cmd = 1'b1;
		// data core reading on an active dat line
		stat.read_active = 1'b1;
		stat.dat_line_act = 1'b1;
		starts = start_cnt;
		axi_write(`SDHC_REG_CMD, cmd_word, `SDHC_CMD_STRB);
		check_value("cmd_issue pulses", starts + 1, start_cnt);
		check_value("cmd_issue command", cmd_word[29:16], start_cmd);
		check_value("cmd_issue argument", arg1, start_arg);
		axi_read(`SDHC_REG_PSTATE, rd);
		check_value("cmd_issue pstate busy", pstate_expect(1'b1), rd);
		stat.com_inh_cmd = 1'b0;
		stat.read_active = 1'b0;
		stat.dat_line_act = 1'b0;
		// data core writing with the dat side inhibited
		stat.write_active = 1'b1;
		stat.cmd_inh_dat = 1'b1;
		axi_read(`SDHC_REG_PSTATE, rd);
		check_value("cmd_issue pstate free", pstate_expect(1'b0), rd);
		stat.write_active = 1'b0;
		stat.cmd_inh_dat = 1'b0;
	endtask

	task automatic interrupt_status();
		logic [31:0] rd;
		int cmd_rsts;
		int dat_rsts;
		stat.cmd_int_st[`SDHC_INT_CMD_CC] = 1'b1;
		axi_write(`SDHC_REG_INTEN, 32'h1, 4'hF);
		axi_write(`SDHC_REG_SIGEN, 32'h1, 4'hF);
		axi_read(`SDHC_REG_INTSTAT, rd);
		check_value("int_status cc enabled", 32'h1, rd);
		check_value("int_status int_out", {29'h1, 29'h1, 29'h1}, int_out);
		axi_write(`SDHC_REG_INTEN, 32'h0, 4'hF);
		axi_read(`SDHC_REG_INTSTAT, rd);
		check_value("int_status cc disabled", 32'h0, rd);
		axi_write(`SDHC_REG_INTEN, 32'h1, 4'hF);
		cmd_rsts = cmd_rst_cnt;
		dat_rsts = dat_rst_cnt;
		// write one to clear while the core still holds cc
		axi_write(`SDHC_REG_INTSTAT, 32'h1, 4'hF);
		check_value("int_status cmd reset", cmd_rsts + 1, cmd_rst_cnt);
		check_value("int_status dat reset", dat_rsts + 1, dat_rst_cnt);
		axi_read(`SDHC_REG_INTSTAT, rd);
		check_value("int_status cleared", 32'h0, rd);
		stat.cmd_int_st = '0;
	endtask

	task automatic auto_cmd23_flow();
		logic [31:0] arg1, arg2, cmd_word, rd;
		logic [5:0] err_bits;
		logic [7:0] exp_err;
		int starts;
		int n;
		arg1 = $urandom;
		arg2 = $urandom;
		cmd_word = $urandom;
		axi_write(`SDHC_REG_ARG1, arg1, 4'hF);
		axi_write(`SDHC_REG_ARG2, arg2, 4'hF);
		axi_write(`SDHC_REG_INTEN, 32'h1 << 24, 4'hF);
		// transfer mode bits 3:2 select auto cmd23
		axi_write(`SDHC_REG_CMD, 32'h0000_0008, 4'h3);
		starts = start_cnt;
		axi_write(`SDHC_REG_CMD, cmd_word, `SDHC_CMD_STRB);
		check_value("acmd23 first pulse", starts + 1, start_cnt);
		check_value("acmd23 cmd23 word", `SDHC_ACMD23_CMD, start_cmd);
		check_value("acmd23 cmd23 argument", arg2, start_arg);
		// card accepts the block count
		stat.resp0 = {16'h0, `SDHC_ACMD23_RESP_OK};
		pulse_cmd_complete();
		n = 0;
		@(negedge clk);
		while (!cmd_start && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!cmd_start)
			report_timeout("restart of the host command");
		check_value("acmd23 host command", cmd_word[29:16], ctrl.command);
		check_value("acmd23 host argument", arg1, ctrl.argument);
		clock_to_drive();
		check_value("acmd23 second pulse", starts + 2, start_cnt);
		// host command done so the sequencer goes idle
		pulse_cmd_complete();
		// card rejects cmd23 this time
		stat.resp0 = 32'h0000_0b00;
		starts = start_cnt;
		axi_write(`SDHC_REG_CMD, cmd_word, `SDHC_CMD_STRB);
		check_value("acmd23 retry pulse", starts + 1, start_cnt);
		check_value("acmd23 retry word", `SDHC_ACMD23_CMD, start_cmd);
		err_bits = '0;
		err_bits[`SDHC_INT_CMD_CIE] = 1'b1;
		err_bits[`SDHC_INT_CMD_CTE] = 1'b1;
		stat.cmd_int_st = err_bits;
		pulse_cmd_complete();
		stat.cmd_int_st = '0;
		exp_err = 8'h00;
		exp_err[4] = err_bits[`SDHC_INT_CMD_CIE];
		exp_err[3] = err_bits[`SDHC_INT_CMD_EI];
		exp_err[2] = err_bits[`SDHC_INT_CMD_CCRCE];
		exp_err[1] = err_bits[`SDHC_INT_CMD_CTE];
		axi_read(`SDHC_REG_INTSTAT, rd);
		check_value("acmd23 error interrupt", 32'h1 << 24, rd);
		axi_read(`SDHC_REG_ACMDERR, rd);
		check_value("acmd23 error status", {24'h0, exp_err}, rd);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		stat = '0;
		errors = 0;
		timeouts = 0;
		start_cnt = 0;
		start_cmd = '0;
		start_arg = '0;
		cmd_rst_cnt = 0;
		dat_rst_cnt = 0;
		srst_cycles = 0;
		srst_code = 2'b00;
		void'($urandom(32'h3412_a23f));
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_constants();
		byte_strobe_writes();
		command_issue();
		interrupt_status();
		auto_cmd23_flow();
		$display("done: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
verilog/sdhc_pkg.sv
verilog/sdhc_axil_slave.sv
verilog/sdhc_regfile.sv
verilog/sdhc_int_status.sv
verilog/sdhc_acmd23_seq.sv
verilog/sdhc_host_regs.sv
dv/tb_sdhc_host_regs.sv

//--- run_sim.sh
#!/bin/sh
# build the register block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_sdhc_host_regs -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0
